/* de2_seg_board.f */
board_pkg.sv
seg_pkg.sv
lab_core.sv
seg_scanner.sv
hex_digit_latch.sv
seg_panel_collector.sv
vga_clk_enable.sv
board_top.sv
tb_clock_gen.sv
tb_board_top.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the board testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_board_top --Mdir obj_dir -f de2_seg_board.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_board_top)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Done: no errors"; then
    exit 0
else
    exit 1
fi

/* tb_board_top.sv */
module tb_board_top
    import board_pkg::*, seg_pkg::*;
();

    localparam int     CLK_PERIOD    = 20;
    localparam int     RESET_CYCLES  = 16;
    localparam int     FRAME_CLKS    = N_DIGITS * SCAN_DIV;
    localparam int     VGA_RATIO     = CLK_MHZ / VGA_MHZ;
    localparam int     INC_ROUNDS    = 3;
    localparam int     MAX_PRESSES   = 12;
    localparam int     LOAD_ROUNDS   = 6;
    localparam int     RESET_FRAMES  = 4;             // Frame budget of each test
    localparam int     INC_FRAMES    = INC_ROUNDS * 9;
    localparam int     LOAD_FRAMES   = (LOAD_ROUNDS + 4) * 4;
    localparam int     DP_FRAMES     = 3 * 4;
    localparam int     MARGIN_FRAMES = 20;
    localparam int     TOTAL_FRAMES  = RESET_FRAMES + INC_FRAMES + LOAD_FRAMES
                                     + DP_FRAMES + MARGIN_FRAMES;
    localparam longint WATCHDOG_TIME = longint' (TOTAL_FRAMES) * FRAME_CLKS * CLK_PERIOD;
    localparam int unsigned RAND_SEED = 32'h5661211d;

    logic                       clk;
    logic                       rst;
    logic [W_KEY    - 1:0]      key;
    logic [W_SW     - 1:0]      sw;
    logic [W_LED    - 1:0]      led;
    logic [N_DIGITS - 1:0][6:0] hex_out;
    logic [N_DIGITS - 1:0]      dp_led;
    logic                       frame_done;
    logic                       vga_clk;

    logic [W_VALUE - 1:0] exp_value;                  // Reference model state
    logic                 exp_dp;
    string                test_name;
    int                   reset_errs;
    int                   timing_errs;
    int                   value_errs;
    bit                   seen_done;
    bit                   done_valid;
    bit                   vga_valid;
    int                   cyc;
    int                   last_done_cyc;
    int                   last_vga_cyc;

    tb_clock_gen #(.PERIOD (CLK_PERIOD), .RESET_CYCLES (RESET_CYCLES)) i_clock_gen
    (
        .clk ( clk ),
        .rst ( rst )
    );

    board_top i_dut
    (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .key        ( key        ),
        .sw         ( sw         ),
        .led        ( led        ),
        .hex_out    ( hex_out    ),
        .dp_led     ( dp_led     ),
        .frame_done ( frame_done ),
        .vga_clk    ( vga_clk    )
    );

    //----------------------------------------------------------------------
    // Reference model

    // Segments lit for a nibble, bit 0 = a up to bit 6 = g
    function automatic logic [6:0] segment_pattern (input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'h3f;   4'h1: return 7'h06;
            4'h2: return 7'h5b;   4'h3: return 7'h4f;
            4'h4: return 7'h66;   4'h5: return 7'h6d;
            4'h6: return 7'h7d;   4'h7: return 7'h07;
            4'h8: return 7'h7f;   4'h9: return 7'h6f;
            4'ha: return 7'h77;   4'hb: return 7'h7c;
            4'hc: return 7'h39;   4'hd: return 7'h5e;
            4'he: return 7'h79;   default: return 7'h71;
        endcase
    endfunction

    task automatic model_press (input logic [W_KEY - 1:0] pressed,
                                input logic [W_SW  - 1:0] sw_now);
        if (pressed [2])
            exp_value = '0;                           // Clear has top priority
        else if (pressed [1])
            exp_value = { 16'h0, sw_now [15:0] };
        else if (pressed [0])
            exp_value = exp_value + 1'b1;
    endtask

    //----------------------------------------------------------------------
    // Stimulus and checks

    task automatic press_keys (input logic [W_KEY - 1:0] pressed, input int hold, input int gap);
        @ (posedge clk);
        key <= ~ pressed;                             // Buttons are active low
        repeat (hold) @ (posedge clk);
        key <= '1;
        repeat (gap) @ (posedge clk);                 // Value settles in two clocks
    endtask

    task automatic wait_frames (input int count);
        repeat (count)
        begin
            @ (negedge clk);
            while (!frame_done)
                @ (negedge clk);
        end
    endtask

    task automatic check_display ();
        logic [6:0]            exp_hex;
        logic [N_DIGITS - 1:0] exp_dp_led;
        exp_dp_led = exp_dp ? '1 : '0;
        for (int d = 0; d < N_DIGITS; d++)
        begin
            exp_hex = ~ segment_pattern (exp_value [4 * d +: 4]);
            assert (hex_out [d] == exp_hex)
            else
            begin
                value_errs++;
                $display ("ERR %s hex digit %0d expected %h actual %h",
                          test_name, d, exp_hex, hex_out [d]);
            end
        end
        assert (dp_led == exp_dp_led)
        else
        begin
            value_errs++;
            $display ("ERR %s dp_led expected %h actual %h", test_name, exp_dp_led, dp_led);
        end
        assert (led == exp_value [W_LED - 1:0])
        else
        begin
            value_errs++;
            $display ("ERR %s led expected %h actual %h",
                      test_name, exp_value [W_LED - 1:0], led);
        end
    endtask

    task automatic load_switches (input logic [W_KEY - 1:0] pressed);
        logic [W_SW - 1:0] sw_next;
        sw_next = W_SW' ($urandom ());
        @ (posedge clk);
        sw <= sw_next;
        exp_dp = sw_next [SW_DP_BIT];
        model_press (pressed, sw_next);
        press_keys (pressed, $urandom_range (5, 1), $urandom_range (8, 2));
        wait_frames (2);
        check_display ();
    endtask

    task automatic set_dp_switch (input logic level);
        @ (posedge clk);
        sw [SW_DP_BIT] <= level;
        exp_dp = level;
        repeat (2) @ (posedge clk);                   // Let dp_mask follow the switch
        wait_frames (2);
        check_display ();
    endtask

    //----------------------------------------------------------------------
    // Monitors

    a_reset_quiet: assert property (@ (posedge clk) rst |-> (!vga_clk && !frame_done))
    else
    begin
        reset_errs++;
        $display ("Reset check: vga_clk or frame_done went high during reset");
    end

    a_blank_start: assert property (@ (posedge clk) !seen_done |-> (hex_out == '1 && dp_led == '0))
    else
    begin
        reset_errs++;
        $display ("Reset check: display not blank before the first refresh");
    end

    a_done_pulse: assert property (@ (posedge clk) disable iff (rst) frame_done |=> !frame_done)
    else
    begin
        timing_errs++;
        $display ("Timing check: frame_done stayed high for more than one clock");
    end

    always @ (negedge clk)
    begin
        if (!rst)
            cyc++;
        if (frame_done)
        begin
            assert (!done_valid || (cyc - last_done_cyc == FRAME_CLKS))
            else
            begin
                timing_errs++;
                $display ("Timing check: frame_done came %0d clocks after the previous one",
                          cyc - last_done_cyc);
            end
            last_done_cyc = cyc;
            done_valid    = 1'b1;
            seen_done     = 1'b1;
        end
        if (vga_clk)
        begin
            assert (!vga_valid || (cyc - last_vga_cyc == VGA_RATIO))
            else
            begin
                timing_errs++;
                $display ("Timing check: vga_clk came %0d clocks after the previous pulse",
                          cyc - last_vga_cyc);
            end
            last_vga_cyc = cyc;
            vga_valid    = 1'b1;
        end
        else if (vga_valid)
        begin
            assert (cyc - last_vga_cyc < VGA_RATIO)
            else
            begin
                timing_errs++;
                $display ("Timing check: vga_clk stayed low for %0d clocks",
                          cyc - last_vga_cyc);
            end
        end
    end

    initial
    begin
        #(WATCHDOG_TIME);
        $display ("Watchdog: run did not finish within %0d frames", TOTAL_FRAMES);
        $display ("Done: errors found");
        $finish;
    end

    //----------------------------------------------------------------------
    // Test sequence

    initial
    begin
        int presses;
        int total_errs;
        void' ($urandom (RAND_SEED));
        key       = '1;                               // All buttons released
        sw        = '0;
        exp_value = '0;
        exp_dp    = 1'b0;

        test_name = "reset";
        @ (negedge clk);
        while (rst)
            @ (negedge clk);
        wait_frames (1);
        check_display ();

        test_name = "increment";
        for (int r = 0; r < INC_ROUNDS; r++)
        begin
            presses = $urandom_range (MAX_PRESSES, 1);
            repeat (presses)
            begin
                model_press (4'b0001, sw);
                press_keys (4'b0001, $urandom_range (5, 1), $urandom_range (8, 2));
            end
            wait_frames (2);
            check_display ();
        end

        test_name = "load";
        repeat (LOAD_ROUNDS)
            load_switches (4'b0010);
        test_name = "clear";
        load_switches (4'b0100);
        test_name = "load";
        load_switches (4'b0010);
        test_name = "clear over load";
        load_switches (4'b0110);                      // Both keys at once

        test_name = "dp off";
        set_dp_switch (1'b0);                         // Start from a known low switch
        test_name = "dp on";
        set_dp_switch (1'b1);
        test_name = "dp off";
        set_dp_switch (1'b0);

        assert (vga_valid)
        else
        begin
            timing_errs++;
            $display ("Timing check: vga_clk never pulsed");
        end

        total_errs = reset_errs + timing_errs + value_errs;
        $display ("Error counts: reset %0d, timing %0d, value %0d",
                  reset_errs, timing_errs, value_errs);
        if (total_errs == 0)
            $display ("Done: no errors");
        else
            $display ("Done: errors found");
        $finish;
    end

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen
#(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 16
)
(
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD / 2) clk = ~ clk;
    end

    initial
    begin
        rst = 1'b0;
        #1 rst = 1'b1;                            // Rising edge fires the async resets
        repeat (RESET_CYCLES) @ (posedge clk);
        rst <= 1'b0;
    end

endmodule

/* board_top.sv */
module board_top
    import board_pkg::*, seg_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic [W_KEY    - 1:0]      key,       // Active low buttons
    input  logic [W_SW     - 1:0]      sw,
    output logic [W_LED    - 1:0]      led,
    output logic [N_DIGITS - 1:0][6:0] hex_out,   // Digit 0 in the low field
    output logic [N_DIGITS - 1:0]      dp_led,
    output logic                       frame_done,
    output logic                       vga_clk
);

    logic [W_KEY    - 1:0]      lab_key;
    logic [W_VALUE  - 1:0]      value;
    logic [N_DIGITS - 1:0]      dp_mask;
    seg_frame_t                 scan_frame;
    digit_out_t [N_DIGITS - 1:0] digit_outs;

    assign lab_key = ~ key;

    //----------------------------------------------------------------------
    // Lab logic and scan

    lab_core i_lab_core
    (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .key     ( lab_key ),
        .sw      ( sw      ),
        .value   ( value   ),
        .dp_mask ( dp_mask ),
        .led     ( led     )
    );

    seg_scanner i_seg_scanner
    (
        .clk     ( clk        ),
        .rst     ( rst        ),
        .value   ( value      ),
        .dp_mask ( dp_mask    ),
        .frame   ( scan_frame )
    );

    //----------------------------------------------------------------------
    // Sticky static digits

    for (genvar i = 0; i < N_DIGITS; i++)
    begin : g_digit
        hex_digit_latch #(.INDEX (i)) i_latch
        (
            .clk       ( clk            ),
            .rst       ( rst            ),
            .frame     ( scan_frame     ),
            .digit_out ( digit_outs [i] )
        );
    end

    seg_panel_collector i_collector
    (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .digits     ( digit_outs ),
        .hex_out    ( hex_out    ),
        .dp_led     ( dp_led     ),
        .frame_done ( frame_done )
    );

    //----------------------------------------------------------------------
    // VGA DAC clock

    vga_clk_enable i_vga_clk_enable
    (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .vga_clk ( vga_clk )
    );

endmodule

/* vga_clk_enable.sv */
module vga_clk_enable
    import board_pkg::*;
(
    input  logic clk,
    input  logic rst,
    output logic vga_clk
);

    logic [W_VGA_CNT - 1:0] div_cnt;

    // One-cycle enable per pixel period
    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            vga_clk <= 1'b0;
        end
        else if (div_cnt == W_VGA_CNT' (VGA_DIV - 1))
        begin
            div_cnt <= '0;
            vga_clk <= 1'b1;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
            vga_clk <= 1'b0;
        end
    end

endmodule

/* seg_panel_collector.sv */
module seg_panel_collector
    import seg_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  digit_out_t [N_DIGITS - 1:0] digits,
    output logic [N_DIGITS - 1:0][6:0]  hex_out,
    output logic [N_DIGITS - 1:0]       dp_led,
    output logic                        frame_done
);

    logic [N_DIGITS - 1:0] updated;
    logic [N_DIGITS - 1:0] refresh_mask;
    logic [N_DIGITS - 1:0] mask_next;
    logic                  frame_complete;

    always_comb
    begin
        for (int i = 0; i < N_DIGITS; i++)
            updated [i] = digits [i].updated;
    end

    assign mask_next      = refresh_mask | updated;
    // Last digit just refreshed and nothing was missed
    assign frame_complete = updated [N_DIGITS - 1] & (& mask_next);

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
        begin
            refresh_mask <= '0;
            frame_done   <= 1'b0;
            hex_out      <= '1;
            dp_led       <= '0;
        end
        else
        begin
            frame_done <= frame_complete;

            if (frame_complete)
            begin
                refresh_mask <= '0;               // Start a new frame
                for (int i = 0; i < N_DIGITS; i++)
                begin
                    hex_out [i] <= digits [i].hex;
                    dp_led  [i] <= digits [i].dp;
                end
            end
            else
            begin
                refresh_mask <= mask_next;
            end
        end
    end

endmodule

/* hex_digit_latch.sv */
module hex_digit_latch
    import seg_pkg::*;
#(
    parameter int INDEX = 0                       // Digit position served
)
(
    input  logic       clk,
    input  logic       rst,
    input  seg_frame_t frame,
    output digit_out_t digit_out
);

    logic [7:0] hgfedcba;
    logic       sel;

    // Reverse so that segment a lands at bit 0
    always_comb
    begin
        for (int i = 0; i < 8; i++)
            hgfedcba [i] = frame.abcdefgh [7 - i];
    end

    assign sel = frame.digit [INDEX];

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
        begin
            digit_out.hex     <= '1;                  // Blank
            digit_out.dp      <= 1'b0;
            digit_out.updated <= 1'b0;
        end
        else
        begin
            if (sel)
            begin
                digit_out.hex <= ~ hgfedcba [6:0];    // HEX pins are active low
                digit_out.dp  <= hgfedcba [7];
            end

            digit_out.updated <= sel;
        end
    end

endmodule

/* seg_scanner.sv */
module seg_scanner
    import seg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [W_VALUE  - 1:0] value,
    input  logic [N_DIGITS - 1:0] dp_mask,
    output seg_frame_t            frame
);

    logic [W_SCAN_CNT  - 1:0] div_cnt;
    logic [W_DIGIT_IDX - 1:0] digit_idx;
    logic                     tick;
    logic [3:0]               nibble;

    //----------------------------------------------------------------------
    // Scan timing

    assign tick = (div_cnt == W_SCAN_CNT' (SCAN_DIV - 1));

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt   <= '0;
            digit_idx <= '0;
        end
        else if (tick)
        begin
            div_cnt <= '0;

            if (digit_idx == W_DIGIT_IDX' (N_DIGITS - 1))
                digit_idx <= '0;                  // Wrap to digit 0
            else
                digit_idx <= digit_idx + 1'b1;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    //----------------------------------------------------------------------
    // Segment frame

    assign nibble = value [4 * digit_idx +: 4];

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
        begin
            frame <= '0;
        end
        else if (tick)
        begin
            frame.abcdefgh <= { hex_font (nibble), dp_mask [digit_idx] };
            frame.digit    <= N_DIGITS' (1) << digit_idx;
        end
        else
        begin
            frame.digit <= '0;                    // Segments stay, strobe drops
        end
    end

endmodule

/* lab_core.sv */
module lab_core
    import board_pkg::*, seg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [W_KEY    - 1:0] key,        // Active high here
    input  logic [W_SW     - 1:0] sw,
    output logic [W_VALUE  - 1:0] value,
    output logic [N_DIGITS - 1:0] dp_mask,
    output logic [W_LED    - 1:0] led
);

    logic [W_KEY - 1:0] key_sync;
    logic [W_KEY - 1:0] key_prev;
    logic [W_KEY - 1:0] key_rise;
    lab_cmd_e           cmd;

    //----------------------------------------------------------------------
    // Key edge detection

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
        begin
            key_sync <= '0;
            key_prev <= '0;
        end
        else
        begin
            key_sync <= key;
            key_prev <= key_sync;
        end
    end

    assign key_rise = key_sync & ~ key_prev;      // Held key counts once

    always_comb
    begin
        cmd = CMD_NONE;
        if (key_rise [2])
            cmd = CMD_CLEAR;                      // Clear wins over load
        else if (key_rise [1])
            cmd = CMD_LOAD;
        else if (key_rise [0])
            cmd = CMD_INC;
    end

    //----------------------------------------------------------------------
    // Value and decimal points

    always_ff @ (posedge clk or posedge rst)
    begin
        if (rst)
        begin
            value   <= '0;
            dp_mask <= '0;
        end
        else
        begin
            case (cmd)
                CMD_INC:   value <= value + 1'b1;
                CMD_LOAD:  value <= W_VALUE' (sw [W_LOAD - 1:0]);
                CMD_CLEAR: value <= '0;
                default:   value <= value;
            endcase

            dp_mask <= { N_DIGITS { sw [SW_DP_BIT] } };
        end
    end

    assign led = value [W_LED - 1:0];

endmodule

/* seg_pkg.sv */
package seg_pkg;

    localparam int N_DIGITS    = 8;
    localparam int W_VALUE     = N_DIGITS * 4;    // One nibble per digit
    localparam int SCAN_DIV    = 4;               // Clocks between scan ticks
    localparam int W_SCAN_CNT  = (SCAN_DIV > 1) ? $clog2 (SCAN_DIV) : 1;
    localparam int W_DIGIT_IDX = $clog2 (N_DIGITS);

    // One digit as a dynamic display would see it
    typedef struct packed
    {
        logic [7:0]            abcdefgh;          // Active high, a on top, dp at bit 0
        logic [N_DIGITS - 1:0] digit;             // One-hot strobe
    } seg_frame_t;

    // One static HEX digit
    typedef struct packed
    {
        logic [6:0] hex;                          // Active low, segment a at bit 0
        logic       dp;
        logic       updated;                      // Single-cycle pulse
    } digit_out_t;

    // Nibble to segments, abcdefg with a on top
    function automatic logic [6:0] hex_font (input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'h7e;   4'h1: return 7'h30;
            4'h2: return 7'h6d;   4'h3: return 7'h79;
            4'h4: return 7'h33;   4'h5: return 7'h5b;
            4'h6: return 7'h5f;   4'h7: return 7'h70;
            4'h8: return 7'h7f;   4'h9: return 7'h7b;
            4'ha: return 7'h77;   4'hb: return 7'h1f;
            4'hc: return 7'h4e;   4'hd: return 7'h3d;
            4'he: return 7'h4f;   default: return 7'h47;
        endcase
    endfunction

endpackage

/* board_pkg.sv */
package board_pkg;

    //----------------------------------------------------------------------
    // Clocking

    localparam int CLK_MHZ   = 50;                // System clock
    localparam int VGA_MHZ   = 25;                // VGA DAC pixel clock
    localparam int VGA_DIV   = CLK_MHZ / VGA_MHZ;
    localparam int W_VGA_CNT = (VGA_DIV > 1) ? $clog2 (VGA_DIV) : 1;

    //----------------------------------------------------------------------
    // Board I/O widths

    localparam int W_KEY     = 4;
    localparam int W_SW      = 17;
    localparam int W_LED     = 18;                // Red lab LEDs

    localparam int W_LOAD    = 16;                // Switches loaded into the value
    localparam int SW_DP_BIT = 16;                // Switch that lights all dp

    // Lab commands, decoded from key edges
    typedef enum logic [1:0]
    {
        CMD_NONE,
        CMD_INC,
        CMD_LOAD,
        CMD_CLEAR
    } lab_cmd_e;

endpackage
